/* common/drive_pkg.sv */
// ====================================================================
// Drive-side types shared by the sense mux and the motor timer
// Spin defaults assume a 14 MHz clock (about 300 ms up, 1 s down)
// ====================================================================

package drive_pkg;

    // Motor inertia counter, wide enough for one second at 14 MHz
    typedef logic [23:0] spin_count_t;

    // One sense line per modeled drive
    typedef logic [2:0] drive_sense_t;

    // Bit positions inside drive_sense_t
    localparam int DRV35_1  = 0;
    localparam int DRV35_2  = 1;
    localparam int DRV525_1 = 2;

    // Default inertia times in CLK_14M cycles
    localparam spin_count_t DEFAULT_SPINUP   = 24'd4200000;
    localparam spin_count_t DEFAULT_SPINDOWN = 24'd14000000;

    // 5.25" motor inertia states
    typedef enum logic [1:0] {
        SPIN_OFF,
        SPIN_UP,
        SPIN_ON,
        SPIN_DOWN
    } spin_state_t;

endpackage

/* common/iwm_pkg.sv */
// ====================================================================
// IWM register map types and soft-switch address codes
// Switch codes are the values of A[3:1]; A[0] carries the new bit
// Status layout follows the IIgs IWM status register read
// ====================================================================

package iwm_pkg;

    // Low address bits decoded by the IWM
    typedef logic [3:0] iwm_addr_t;

    // CPU data byte
    typedef logic [7:0] iwm_data_t;

    // Stepper phase lines PH0..PH3
    typedef logic [3:0] phase_t;

    // Stored mode register bits
    typedef logic [4:0] mode_t;

    // Latched sense index from the last phase access
    typedef logic [2:0] sense_reg_t;

    // Soft-switch codes on A[3:1]
    localparam logic [2:0] SW_PHASE0    = 3'd0;
    localparam logic [2:0] SW_PHASE1    = 3'd1;
    localparam logic [2:0] SW_PHASE2    = 3'd2;
    localparam logic [2:0] SW_PHASE3    = 3'd3;
    localparam logic [2:0] SW_MOTOR     = 3'd4;
    localparam logic [2:0] SW_DRIVE_SEL = 3'd5;
    localparam logic [2:0] SW_Q6        = 3'd6;
    localparam logic [2:0] SW_Q7        = 3'd7;

    // Status register bit positions
    localparam int STATUS_SENSE_BIT = 7;
    localparam int STATUS_MOTOR_BIT = 5;

    // Byte returned for reads the IWM does not model
    localparam iwm_data_t READ_IDLE = 8'hFF;

endpackage

/* rtl/iwm/iwm_soft_switches.sv */
// ====================================================================
// IWM soft-switch state, updated once per CPU access
// Update happens on the first PH2-qualified edge of DEVICE_SELECT
// device_select must drop for one edge before the next update
// Immediate outputs are combinational and valid during the access
// ====================================================================

`timescale 1ns/100ps

module iwm_soft_switches (
    input  logic                CLK_14M,
    input  logic                RESET,
    input  logic                device_select,
    input  logic                wr_cycle,
    input  logic                ph2,
    input  iwm_pkg::iwm_addr_t  a,
    input  iwm_pkg::iwm_data_t  d_in,
    output iwm_pkg::phase_t     phases,
    output logic                drive_on,
    output logic                drive_sel,
    output logic                cpu_rd,
    output logic                imm_q6,
    output logic                imm_q7,
    output logic                imm_motor,
    output iwm_pkg::mode_t      imm_mode,
    output iwm_pkg::sense_reg_t sense_reg
);
    import iwm_pkg::*;

    // Switch state not exported directly
    logic       q6;
    logic       q7;
    mode_t      mode_reg;

    // Access tracking
    logic       access_seen;
    logic       access_edge;
    logic       cpu_wr;

    // Decode helpers
    logic [2:0] sw_sel;
    logic       mode_wr;
    phase_t     next_phases;

    // ==================================================================
    // Access decode
    // ==================================================================

    // wr_cycle high marks a read
    assign cpu_rd = device_select && wr_cycle;
    assign cpu_wr = device_select && !wr_cycle;

    // First PH2 edge of an access not yet serviced
    assign access_edge = device_select && ph2 && !access_seen;

    assign sw_sel = a[3:1];

    // Phase lines as they will be after this access
    always_comb begin
        next_phases = phases;
        next_phases[a[2:1]] = a[0];
    end

    // ==================================================================
    // Immediate values seen by the read path
    // ==================================================================

    // Accessed switch shows its new bit right away
    assign imm_q6    = (device_select && sw_sel == SW_Q6) ? a[0] : q6;
    assign imm_q7    = (device_select && sw_sel == SW_Q7) ? a[0] : q7;
    assign imm_motor = (device_select && sw_sel == SW_MOTOR) ? a[0] : drive_on;

    // Mode write needs motor off, Q6 and Q7 set, odd address
    assign mode_wr  = cpu_wr && !drive_on && imm_q6 && imm_q7 && a[0];
    assign imm_mode = mode_wr ? d_in[4:0] : mode_reg;

    // ==================================================================
    // Switch registers
    // ==================================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            phases      <= '0;
            drive_on    <= 1'b0;
            drive_sel   <= 1'b0;
            q6          <= 1'b0;
            q7          <= 1'b0;
            mode_reg    <= '0;
            sense_reg   <= '0;
            access_seen <= 1'b0;
        end else begin
            // Re-arm once the select goes away
            if (!device_select) begin
                access_seen <= 1'b0;
            end
            if (access_edge) begin
                access_seen <= 1'b1;
                case (sw_sel)
                    // Set or clear alike latches the sense index
                    SW_PHASE0, SW_PHASE1, SW_PHASE2, SW_PHASE3: begin
                        phases    <= next_phases;
                        sense_reg <= next_phases[2:0];
                    end
                    SW_MOTOR:     drive_on  <= a[0];
                    SW_DRIVE_SEL: drive_sel <= a[0];
                    SW_Q6:        q6        <= a[0];
                    SW_Q7:        q7        <= a[0];
                endcase
                if (mode_wr) begin
                    mode_reg <= d_in[4:0];
                end
            end
        end
    end

    // Mode is frozen for as long as the motor is commanded on
    a_mode_stable_motor_on : assert property (
        @(posedge CLK_14M) disable iff (RESET)
        drive_on |=> $stable(mode_reg)
    );

endmodule

/* rtl/iwm/iwm_status_read.sv */
// ====================================================================
// IWM status register read path
// Only Q6=1, Q7=0 reads are modeled; all others return all ones
// Absent 5.25" drive 2 and a stopped motor both read sense as one
// ====================================================================

`timescale 1ns/100ps

module iwm_status_read (
    input  logic                    cpu_rd,
    input  logic                    imm_q6,
    input  logic                    imm_q7,
    input  logic                    imm_motor,
    input  logic                    drive_on,
    input  logic                    drive_sel,
    input  logic                    is_35_inch,
    input  iwm_pkg::mode_t          imm_mode,
    input  drive_pkg::drive_sense_t drive_sense,
    output iwm_pkg::iwm_data_t      d_out
);
    import iwm_pkg::*;
    import drive_pkg::*;

    logic      drive_bit;
    logic      sense;
    iwm_data_t status;

    // Pick the sense line of the selected drive
    always_comb begin
        if (is_35_inch) begin
            drive_bit = drive_sel ? drive_sense[DRV35_2] : drive_sense[DRV35_1];
        end else begin
            // No second 5.25" drive, line floats high
            drive_bit = drive_sel ? 1'b1 : drive_sense[DRV525_1];
        end
    end

    // No drive is enabled while the motor is off
    assign sense = drive_on ? drive_bit : 1'b1;

    // Status byte, bit 6 stays zero
    always_comb begin
        status                   = '0;
        status[4:0]              = imm_mode;
        status[STATUS_MOTOR_BIT] = imm_motor;
        status[STATUS_SENSE_BIT] = sense;
    end

    // Status on Q6 high, Q7 low
    assign d_out = (cpu_rd && imm_q6 && !imm_q7) ? status : READ_IDLE;

endmodule

/* rtl/iwm_control.sv */
// ====================================================================
// IWM soft-switch controller top level
// No flux or data registers; reads other than status return all ones
// disk35 bit 6 selects 3.5" drives, other bits are ignored
// Phase, sense index and select go out to external drive models
// ====================================================================

`timescale 1ns/100ps

module iwm_control #(
    parameter drive_pkg::spin_count_t SPINUP_CYCLES   = drive_pkg::DEFAULT_SPINUP,
    parameter drive_pkg::spin_count_t SPINDOWN_CYCLES = drive_pkg::DEFAULT_SPINDOWN
) (
    input  logic                    CLK_14M,
    input  logic                    RESET,
    input  logic                    device_select,
    input  logic                    wr_cycle,
    input  logic                    ph2,
    input  iwm_pkg::iwm_addr_t      a,
    input  iwm_pkg::iwm_data_t      d_in,
    input  iwm_pkg::iwm_data_t      disk35,
    input  drive_pkg::drive_sense_t drive_sense,
    output iwm_pkg::iwm_data_t      d_out,
    output iwm_pkg::phase_t         phases,
    output iwm_pkg::sense_reg_t     sense_reg,
    output logic                    drive_on,
    output logic                    drive_sel,
    output logic                    floppy_motor_on
);
    import iwm_pkg::*;

    // 3.5" flag from the disk register
    logic  is_35_inch;

    // Same-access values from the switch block
    logic  cpu_rd;
    logic  imm_q6;
    logic  imm_q7;
    logic  imm_motor;
    mode_t imm_mode;

    assign is_35_inch = disk35[6];

    // ==================================================================
    // Soft switches
    // ==================================================================

    iwm_soft_switches i_soft_switches (
        .CLK_14M       (CLK_14M),
        .RESET         (RESET),
        .device_select (device_select),
        .wr_cycle      (wr_cycle),
        .ph2           (ph2),
        .a             (a),
        .d_in          (d_in),
        .phases        (phases),
        .drive_on      (drive_on),
        .drive_sel     (drive_sel),
        .cpu_rd        (cpu_rd),
        .imm_q6        (imm_q6),
        .imm_q7        (imm_q7),
        .imm_motor     (imm_motor),
        .imm_mode      (imm_mode),
        .sense_reg     (sense_reg)
    );

    // Status read and sense mux
    iwm_status_read i_status_read (
        .cpu_rd      (cpu_rd),
        .imm_q6      (imm_q6),
        .imm_q7      (imm_q7),
        .imm_motor   (imm_motor),
        .drive_on    (drive_on),
        .drive_sel   (drive_sel),
        .is_35_inch  (is_35_inch),
        .imm_mode    (imm_mode),
        .drive_sense (drive_sense),
        .d_out       (d_out)
    );

    // 5.25" inertia, drives the clock slowdown request
    motor_spin_timer #(
        .SPINUP_CYCLES   (SPINUP_CYCLES),
        .SPINDOWN_CYCLES (SPINDOWN_CYCLES)
    ) i_motor_timer (
        .CLK_14M        (CLK_14M),
        .RESET          (RESET),
        .drive_on       (drive_on),
        .is_35_inch     (is_35_inch),
        .motor_spinning (floppy_motor_on)
    );

endmodule

/* rtl/motor_spin_timer.sv */
// ====================================================================
// 5.25" motor inertia model
// Output rises SPINUP_CYCLES+1 edges after the first edge seeing on
// Output falls SPINDOWN_CYCLES+1 edges after drive_on drops
// 3.5" mode holds the timer off; Sony drives spin on their own
// ====================================================================

`timescale 1ns/100ps

module motor_spin_timer #(
    parameter drive_pkg::spin_count_t SPINUP_CYCLES   = drive_pkg::DEFAULT_SPINUP,
    parameter drive_pkg::spin_count_t SPINDOWN_CYCLES = drive_pkg::DEFAULT_SPINDOWN
) (
    input  logic CLK_14M,
    input  logic RESET,
    input  logic drive_on,
    input  logic is_35_inch,
    output logic motor_spinning
);
    import drive_pkg::*;

    spin_state_t state;
    spin_count_t count;

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            state <= SPIN_OFF;
            count <= '0;
        end else if (is_35_inch) begin
            // Timer idles in 3.5" mode
            state <= SPIN_OFF;
            count <= '0;
        end else begin
            case (state)
                SPIN_OFF: begin
                    if (drive_on) begin
                        state <= SPIN_UP;
                        count <= '0;
                    end
                end
                SPIN_UP: begin
                    // Off during spin-up aborts without a spin-down
                    if (!drive_on) begin
                        state <= SPIN_OFF;
                    end else if (count == SPINUP_CYCLES) begin
                        state <= SPIN_ON;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                SPIN_ON: begin
                    if (!drive_on) begin
                        state <= SPIN_DOWN;
                        count <= SPINDOWN_CYCLES;
                    end
                end
                SPIN_DOWN: begin
                    // Back on before the platter stops
                    if (drive_on) begin
                        state <= SPIN_ON;
                    end else if (count <= spin_count_t'(1)) begin
                        state <= SPIN_OFF;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= SPIN_OFF;
            endcase
        end
    end

    assign motor_spinning = (state == SPIN_ON) || (state == SPIN_DOWN);

    // Only the edge right after the 3.5" flag rises may still show spin
    a_no_spin_in_35 : assert property (
        @(posedge CLK_14M) disable iff (RESET)
        (is_35_inch && $past(is_35_inch)) |-> !motor_spinning
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the IWM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_iwm_control -o sim_iwm_control

./obj_dir/sim_iwm_control | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

/* sim.f */
+incdir+sim
common/iwm_pkg.sv
common/drive_pkg.sv
rtl/iwm/iwm_soft_switches.sv
rtl/iwm/iwm_status_read.sv
rtl/motor_spin_timer.sv
rtl/iwm_control.sv
sim/tb_iwm_control.sv

/* sim/tb_iwm_tests.svh */
// ====================================================================
// Directed tests for the IWM controller, included in the testbench
// Tests run in order and rely on the switch state left by earlier ones
// Mode 1F stays stored from the mode test onward
// ====================================================================

`ifndef TB_IWM_TESTS_SVH
`define TB_IWM_TESTS_SVH

// ====================================================================
// Checks and reporting
// ====================================================================

task automatic expect_equal(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
        $display("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp);
        errors++;
    end
endtask

// One line per finished test
task automatic report_test(input string name, input int errors_at_start);
    if (errors == errors_at_start) begin
        $display("test %s: ok", name);
    end else begin
        $display("test %s: %0d error(s)", name, errors - errors_at_start);
    end
endtask

// Status layout: sense in 7, zero in 6, motor in 5, mode in 4:0
function automatic iwm_data_t status_byte(input logic sense, input logic motor,
                                          input mode_t mode);
    return {sense, 1'b0, motor, mode};
endfunction

// Edges after the update edge until the motor output reaches level
// Zero means it never got there within limit edges
task automatic edges_until_motor(input logic level, input int limit, output int edges);
    int n;
    edges = 0;
    for (n = 1; n <= limit && edges == 0; n++) begin
        @(negedge CLK_14M);
        if (floppy_motor_on == level) begin
            edges = n;
        end else begin
            @(posedge CLK_14M);
        end
    end
endtask

// ====================================================================
// Tests
// ====================================================================

task automatic check_reset_state;
    int        mark;
    iwm_data_t rd;
    mark = errors;
    @(negedge CLK_14M);
    expect_equal("phases", phases, 0);
    expect_equal("sense_reg", sense_reg, 0);
    expect_equal("drive_on", drive_on, 0);
    expect_equal("drive_sel", drive_sel, 0);
    expect_equal("floppy_motor_on", floppy_motor_on, 0);
    // Q6 on; sense reads one with the motor off
    cpu_read(4'hD, rd);
    expect_equal("d_out", rd, status_byte(1'b1, 1'b0, 5'h00));
    report_test("reset state", mark);
endtask

task automatic walk_phases;
    int     mark;
    int     p;
    logic   bit_val;
    phase_t exp_ph;
    mark   = errors;
    exp_ph = '0;
    // Set PH0..PH3 in turn, then clear them
    for (int step = 0; step < 8; step++) begin
        p       = step % 4;
        bit_val = (step < 4);
        exp_ph[p] = bit_val;
        cpu_write(iwm_addr_t'(p * 2 + int'(bit_val)), 8'h00);
        @(negedge CLK_14M);
        expect_equal("phases", phases, exp_ph);
        expect_equal("sense_reg", sense_reg, exp_ph[2:0]);
    end
    report_test("phases and sense latch", mark);
endtask

task automatic mode_register_write;
    int        mark;
    iwm_data_t rd;
    mark = errors;
    cpu_read(4'hD, rd);
    // Q7 on at an odd address with motor off stores the mode
    cpu_write(4'hF, 8'h1F);
    cpu_read(4'hE, rd);
    cpu_read(4'hD, rd);
    expect_equal("d_out after mode write", rd, status_byte(1'b1, 1'b0, 5'h1F));
    // Motor on blocks the write
    cpu_write(4'h9, 8'h00);
    cpu_write(4'hF, 8'h05);
    cpu_read(4'hE, rd);
    expect_equal("d_out with motor on", rd,
                 status_byte(drive_sense[DRV525_1], 1'b1, 5'h1F));
    cpu_write(4'h8, 8'h00);
    report_test("mode register", mark);
endtask

task automatic sense_mux_readback;
    int           mark;
    logic         exp_sense;
    drive_sense_t pattern;
    iwm_data_t    rd;
    mark = errors;
    // Motor bit shows on the read that turns it on
    cpu_read(4'h9, rd);
    expect_equal("d_out[5] on motor-on read", rd[5], 1);
    // cfg bit 1 is the 3.5" flag, bit 0 the drive select
    for (int cfg = 0; cfg < 4; cfg++) begin
        disk35 <= (cfg >= 2) ? 8'h40 : 8'h00;
        cpu_write((cfg % 2 == 1) ? 4'hB : 4'hA, 8'h00);
        @(negedge CLK_14M);
        expect_equal("drive_sel", drive_sel, cfg % 2);
        @(posedge CLK_14M);
        for (int ds = 0; ds < 8; ds++) begin
            pattern = drive_sense_t'(ds);
            drive_sense <= pattern;
            cpu_read(4'hD, rd);
            if (cfg >= 2) begin
                exp_sense = (cfg % 2 == 1) ? pattern[DRV35_2] : pattern[DRV35_1];
            end else begin
                // Absent 5.25" drive 2 reads one
                exp_sense = (cfg % 2 == 1) ? 1'b1 : pattern[DRV525_1];
            end
            expect_equal("d_out sense", rd, status_byte(exp_sense, 1'b1, 5'h1F));
        end
    end
    cpu_write(4'h8, 8'h00);
    cpu_write(4'hA, 8'h00);
    disk35      <= 8'h00;
    drive_sense <= '0;
    report_test("immediate motor and sense mux", mark);
endtask

task automatic motor_spin_timing;
    int   mark;
    int   edges;
    logic saw_spin;
    mark = errors;
    // Let any spin-down from earlier tests finish
    edges_until_motor(1'b0, 60, edges);
    assert (edges != 0) else begin
        $display("timeout: floppy_motor_on did not fall before the timing test");
        errors++;
    end
    cpu_write(4'h9, 8'h00);
    edges_until_motor(1'b1, 30, edges);
    checks++;
    assert (edges > 20 && edges <= 23) else begin
        $display("CHECK FAILED at %0t: floppy_motor_on rose after %0d edges, expected 21..23",
                 $time, edges);
        errors++;
    end
    cpu_write(4'h8, 8'h00);
    edges_until_motor(1'b0, 50, edges);
    checks++;
    assert (edges > 40 && edges <= 43) else begin
        $display("CHECK FAILED at %0t: floppy_motor_on fell after %0d edges, expected 41..43",
                 $time, edges);
        errors++;
    end
    // 3.5" drives leave the timer idle
    @(posedge CLK_14M);
    disk35 <= 8'h40;
    cpu_write(4'h9, 8'h00);
    saw_spin = 1'b0;
    for (int n = 0; n < 30; n++) begin
        @(negedge CLK_14M);
        saw_spin = saw_spin | floppy_motor_on;
    end
    expect_equal("floppy_motor_on in 3.5 inch mode", saw_spin, 0);
    cpu_write(4'h8, 8'h00);
    disk35 <= 8'h00;
    report_test("motor timing", mark);
endtask

task automatic single_update_per_access;
    int mark;
    mark = errors;
    @(posedge CLK_14M);
    device_select <= 1'b1;
    ph2           <= 1'b1;
    wr_cycle      <= 1'b0;
    a             <= 4'h1;
    // Update edge, then A[0] flips while select stays high
    @(posedge CLK_14M);
    @(posedge CLK_14M);
    a <= 4'h0;
    repeat (3) @(posedge CLK_14M);
    @(negedge CLK_14M);
    expect_equal("phases[0] mid-access", phases[0], 1);
    @(posedge CLK_14M);
    device_select <= 1'b0;
    ph2           <= 1'b0;
    @(posedge CLK_14M);
    @(negedge CLK_14M);
    expect_equal("phases[0] after select drop", phases[0], 1);
    // A fresh access takes effect
    cpu_write(4'h0, 8'h00);
    @(negedge CLK_14M);
    expect_equal("phases[0] after new access", phases[0], 0);
    report_test("one update per access", mark);
endtask

`endif

/* sim/tb_iwm_control.sv */
// ====================================================================
// Testbench for the IWM soft-switch controller
// Short spin counts (20 up, 40 down) keep the motor tests brief
// Inputs change on the rising edge, outputs are sampled on the falling
// ====================================================================

`timescale 1ns/100ps

module tb_iwm_control;
    import iwm_pkg::*;
    import drive_pkg::*;

    localparam spin_count_t TB_SPINUP   = 24'd20;
    localparam spin_count_t TB_SPINDOWN = 24'd40;

    // DUT inputs
    logic         CLK_14M;
    logic         RESET;
    logic         device_select;
    logic         wr_cycle;
    logic         ph2;
    iwm_addr_t    a;
    iwm_data_t    d_in;
    iwm_data_t    disk35;
    drive_sense_t drive_sense;

    // DUT outputs
    iwm_data_t    d_out;
    phase_t       phases;
    sense_reg_t   sense_reg;
    logic         drive_on;
    logic         drive_sel;
    logic         floppy_motor_on;

    // Check bookkeeping
    int           checks;
    int           errors;

    iwm_control #(
        .SPINUP_CYCLES   (TB_SPINUP),
        .SPINDOWN_CYCLES (TB_SPINDOWN)
    ) i_iwm_control (
        .CLK_14M         (CLK_14M),
        .RESET           (RESET),
        .device_select   (device_select),
        .wr_cycle        (wr_cycle),
        .ph2             (ph2),
        .a               (a),
        .d_in            (d_in),
        .disk35          (disk35),
        .drive_sense     (drive_sense),
        .d_out           (d_out),
        .phases          (phases),
        .sense_reg       (sense_reg),
        .drive_on        (drive_on),
        .drive_sel       (drive_sel),
        .floppy_motor_on (floppy_motor_on)
    );

    // 50 MHz nominal, 20 ns period
    always #10 CLK_14M = ~CLK_14M;

    // ==================================================================
    // CPU bus
    // ==================================================================

    // Select and PH2 high for two edges, then one idle edge
    // The idle edge is the first edge of the next access
    task automatic bus_access(
        input  iwm_addr_t addr,
        input  logic      is_read,
        input  iwm_data_t wdata,
        output iwm_data_t rdata
    );
        @(posedge CLK_14M);
        device_select <= 1'b1;
        ph2           <= 1'b1;
        wr_cycle      <= is_read;
        a             <= addr;
        d_in          <= wdata;
        // Immediate values are visible before the update edge
        @(negedge CLK_14M);
        rdata = d_out;
        // Update edge, then the second PH2 edge
        @(posedge CLK_14M);
        @(posedge CLK_14M);
        device_select <= 1'b0;
        ph2           <= 1'b0;
    endtask

    // wr_cycle high marks a read
    task automatic cpu_read(input iwm_addr_t addr, output iwm_data_t rdata);
        bus_access(addr, 1'b1, 8'h00, rdata);
    endtask

    task automatic cpu_write(input iwm_addr_t addr, input iwm_data_t wdata);
        iwm_data_t unused;
        bus_access(addr, 1'b0, wdata, unused);
    endtask

    `include "tb_iwm_tests.svh"

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial begin
        CLK_14M       = 1'b0;
        RESET         = 1'b1;
        device_select = 1'b0;
        wr_cycle      = 1'b1;
        ph2           = 1'b0;
        a             = '0;
        d_in          = '0;
        disk35        = '0;
        drive_sense   = '0;
        checks        = 0;
        errors        = 0;

        repeat (4) @(posedge CLK_14M);
        RESET <= 1'b0;

        check_reset_state;
        walk_phases;
        mode_register_write;
        sense_mux_readback;
        motor_spin_timing;
        single_update_per_access;

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
